// File: Bender.yml
package:
  name: pet_io

sources:
  # Packages first, the modules import them
  - rtl/pet_bus_pkg.sv
  - rtl/pet_io_pkg.sv
  - rtl/bus_timing.sv
  - rtl/address_decoding.sv
  - rtl/keyboard.sv
  - rtl/pet_io_top.sv
  - target: test
    files:
      - tb/pet_io_assert.sv
      - tb/pet_io_tb.sv

// File: files.f
rtl/pet_bus_pkg.sv
rtl/pet_io_pkg.sv
rtl/bus_timing.sv
rtl/address_decoding.sv
rtl/keyboard.sv
rtl/pet_io_top.sv
tb/pet_io_assert.sv
tb/pet_io_tb.sv

// File: rtl/address_decoding.sv
/* CPU and host address decoder */

module address_decoding (
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [pet_bus_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    output logic                                   pia1_cs_o,
    output logic                                   pia2_cs_o,
    output logic                                   via_cs_o,
    output logic [pet_io_pkg::VIA_RS_WIDTH-1:0]    rs_o,       // A3..A0 to the chips
    output logic                                   wb_sel_o    // Host hit on the register file
);
    import pet_bus_pkg::*;
    import pet_io_pkg::*;

    localparam int CS_WIDTH = CPU_CS_MSB - CPU_CS_LSB + 1;

    logic                io_page_hit;   // E800..E87F
    logic [CS_WIDTH-1:0] chip_bits;     // A6..A4

    // All three chips share the upper address bits
    assign io_page_hit = (cpu_addr_i[CPU_ADDR_WIDTH-1:CPU_CS_MSB+1]
                          == CPU_PIA1_BASE[CPU_ADDR_WIDTH-1:CPU_CS_MSB+1]);

    assign chip_bits = cpu_addr_i[CPU_CS_MSB:CPU_CS_LSB];

    // The PET only looks at one of A4, A5, A6 per chip
    // Requiring an exact match keeps the selects one-hot
    always_comb begin
        pia1_cs_o = 1'b0;
        pia2_cs_o = 1'b0;
        via_cs_o  = 1'b0;
        if (io_page_hit) begin
            pia1_cs_o = (chip_bits == CPU_PIA1_BASE[CPU_CS_MSB:CPU_CS_LSB]);
            pia2_cs_o = (chip_bits == CPU_PIA2_BASE[CPU_CS_MSB:CPU_CS_LSB]);
            via_cs_o  = (chip_bits == CPU_VIA_BASE[CPU_CS_MSB:CPU_CS_LSB]);   // Selects E840
        end
    end

    // PIA uses the low two of these, VIA all four
    assign rs_o = cpu_addr_i[VIA_RS_WIDTH-1:0];

    // Register file occupies a 64-byte window on the host bus
    assign wb_sel_o = (wb_addr_i[WB_ADDR_WIDTH-1:IO_REG_ADDR_WIDTH]
                       == WB_IO_BASE[WB_ADDR_WIDTH-1:IO_REG_ADDR_WIDTH]);

endmodule

// File: rtl/bus_timing.sv
/* Bus slot sequencer */

module bus_timing (
    input  logic wb_clock_i,
    input  logic reset_i,
    output logic cpu_be_o               // High during the CPU slot
);
    import pet_bus_pkg::*;

    bus_slot_e slot_q;
    bus_slot_e slot_d;

    // Fixed rotation, the host owns three slots in a row
    always_comb begin
        unique case (slot_q)
            SLOT_WB0: slot_d = SLOT_WB1;
            SLOT_WB1: slot_d = SLOT_WB2;
            SLOT_WB2: slot_d = SLOT_CPU;    // Last host slot before the CPU
            SLOT_CPU: slot_d = SLOT_WB0;
            default:  slot_d = SLOT_WB0;
        endcase
    end

    // Starting in WB0 puts the first CPU slot on the fourth cycle out of reset
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            slot_q <= SLOT_WB0;
        end else begin
            slot_q <= slot_d;
        end
    end

    // Straight from the state flop, so no decode glitch reaches the pins
    assign cpu_be_o = (slot_q == SLOT_CPU);

endmodule

// File: rtl/keyboard.sv
/* I/O snooping register file and keyboard intercept */

module keyboard (
    input  logic                                wb_clock_i,
    input  logic                                reset_i,

    // Wishbone B4 pipelined peripheral
    input  pet_bus_pkg::wb_req_t                wb_req_i,
    input  logic                                wb_sel_i,     // From address_decoding
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  wb_data_o,
    output logic                                wb_ack_o,
    output logic                                wb_stall_o,

    // Snooped 6502 bus
    input  logic                                cpu_be_i,
    input  logic                                cpu_we_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  cpu_data_i,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  cpu_data_o,
    output logic                                cpu_data_oe_o, // Overrides the chip's data
    input  logic                                pia1_cs_i,
    input  logic                                pia2_cs_i,
    input  logic                                via_cs_i,
    input  logic [pet_io_pkg::VIA_RS_WIDTH-1:0] rs_i
);
    import pet_bus_pkg::*;
    import pet_io_pkg::*;

    // Cached chip registers plus the host keyboard matrix
    logic [DATA_WIDTH-1:0] regs [IO_REG_COUNT];

    logic [PIA_RS_WIDTH-1:0]      pia_rs;
    logic [IO_REG_ADDR_WIDTH-1:0] wb_rs;
    logic [IO_REG_ADDR_WIDTH-1:0] cpu_wr_addr;
    logic                         cpu_wr_en;
    logic                         wb_accept;
    logic                         portb_read;
    logic                         col_idle;

    logic [KEY_SEL_WIDTH-1:0]     selected_col;   // Stage 1 of the column pipeline
    logic [DATA_WIDTH-1:0]        current_col;    // Stage 2, rows of the selected column

    assign pia_rs = rs_i[PIA_RS_WIDTH-1:0];                  // PIA sees A1..A0 only
    assign wb_rs  = wb_req_i.address[IO_REG_ADDR_WIDTH-1:0]; // Offset inside the host window

    // The CPU slot is the only back-pressure
    assign wb_stall_o = cpu_be_i;

    assign wb_accept = wb_req_i.cycle && wb_req_i.strobe && wb_sel_i && !wb_stall_o;

    // Map the active chip onto its group
    always_comb begin
        cpu_wr_addr = {REG_IO_VIA, rs_i};
        if (pia1_cs_i) begin
            cpu_wr_addr = {REG_IO_PIA1, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, pia_rs};
        end else if (pia2_cs_i) begin
            cpu_wr_addr = {REG_IO_PIA2, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, pia_rs};
        end
    end

    assign cpu_wr_en = cpu_be_i && cpu_we_i && (pia1_cs_i || pia2_cs_i || via_cs_i);

    // Keyboard rows are read through PIA1 port B
    assign portb_read = cpu_be_i && !cpu_we_i && pia1_cs_i && (pia_rs == PIA_PORTB);

    // Neither bus touches the file, so the column lookup gets the read port
    assign col_idle = !cpu_be_i && !wb_accept;

    // Register file
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < IO_REG_COUNT; i++) begin
                regs[i] <= (i < KEY_COL_COUNT) ? KEY_COL_IDLE : '0;  // No keys down
            end
        end else if (cpu_wr_en) begin
            regs[cpu_wr_addr] <= cpu_data_i;           // CPU wins over the host
        end else if (wb_accept && wb_req_i.we) begin
            regs[wb_rs] <= wb_req_i.data;
        end
    end

    // Handshake strobes and the column pipeline
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o      <= 1'b0;
            cpu_data_oe_o <= 1'b0;
            selected_col  <= '0;
            current_col   <= KEY_COL_IDLE;
        end else begin
            wb_ack_o      <= wb_accept;                // Single-cycle completion
            cpu_data_oe_o <= portb_read && (current_col != KEY_COL_IDLE);
            if (col_idle) begin
                // Two stages, PORTA changes settle within two idle cycles
                selected_col <= regs[REG_IO_PIA1_PORTA][KEY_SEL_WIDTH-1:0];
                current_col  <= regs[{REG_IO_KBD, selected_col}];
            end
        end
    end

    // Read data
    always_ff @(posedge wb_clock_i) begin
        if (wb_accept) begin
            wb_data_o <= regs[wb_rs];                  // Value before any write in this request
        end
        if (portb_read) begin
            cpu_data_o <= current_col;
        end
    end

endmodule

// File: rtl/pet_bus_pkg.sv
/* PET bus definitions */

package pet_bus_pkg;

    // 6502 side
    localparam int CPU_ADDR_WIDTH = 16;     // Full 64K CPU address space
    localparam int DATA_WIDTH     = 8;      // Shared by the CPU bus and Wishbone

    // Host side
    localparam int WB_ADDR_WIDTH  = 17;     // Host sees 128K of address space

    // Bus sharing
    localparam int CPU_SLOT_CYCLES = 4;     // One CPU slot per this many clocks
    localparam int SLOT_WIDTH      = $clog2(CPU_SLOT_CYCLES);

    // Snapshot of the 6502 bus as seen by the FPGA
    typedef struct packed {
        logic [CPU_ADDR_WIDTH-1:0] address;  // A15..A0
        logic [DATA_WIDTH-1:0]     data;     // Write data from the CPU
        logic                      we;       // High for a CPU write (inverted R/W)
    } cpu_bus_t;

    // Wishbone B4 pipelined request from the host
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]    data;      // Write data
        logic                     we;        // Write enable
        logic                     cycle;     // CYC_O of the master
        logic                     strobe;    // STB_O of the master
    } wb_req_t;

    // Slots of the bus sharing sequence
    // The CPU owns one slot and the host the other three
    typedef enum logic [SLOT_WIDTH-1:0] {
        SLOT_CPU,
        SLOT_WB0,
        SLOT_WB1,
        SLOT_WB2
    } bus_slot_e;

endpackage

// File: rtl/pet_io_pkg.sv
/* PET I/O register map */

package pet_io_pkg;

    // Register file addressing
    localparam int IO_REG_ADDR_WIDTH = 6;
    localparam int IO_REG_COUNT      = 1 << IO_REG_ADDR_WIDTH;

    // Chip register selects
    localparam int PIA_RS_WIDTH = 2;        // PIA decodes A1..A0
    localparam int VIA_RS_WIDTH = 4;        // VIA decodes A3..A0

    // Upper two bits of a register address pick the group
    typedef enum logic [IO_REG_ADDR_WIDTH-VIA_RS_WIDTH-1:0] {
        REG_IO_KBD,                         // Host written keyboard matrix
        REG_IO_PIA1,
        REG_IO_PIA2,
        REG_IO_VIA
    } io_group_e;

    // MC6821 register order
    typedef enum logic [PIA_RS_WIDTH-1:0] {
        PIA_PORTA,
        PIA_CRA,
        PIA_PORTB,
        PIA_CRB
    } pia_reg_e;

    // Cached PIA1 port A, which drives the matrix column select
    localparam logic [IO_REG_ADDR_WIDTH-1:0] REG_IO_PIA1_PORTA =
        {REG_IO_PIA1, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, PIA_PORTA};

    // Keyboard matrix
    localparam int KEY_COL_COUNT = 10;      // 10 columns of 8 rows
    localparam int KEY_SEL_WIDTH = 4;       // PA3..PA0 select the column
    localparam logic [pet_bus_pkg::DATA_WIDTH-1:0] KEY_COL_IDLE = '1;  // Active low rows

    // Host window holding the register file
    localparam logic [pet_bus_pkg::WB_ADDR_WIDTH-1:0] WB_IO_BASE = 17'h0e800;

    // CPU side chip bases, A6..A4 act as individual chip selects
    localparam logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] CPU_PIA1_BASE = 16'he810;
    localparam logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] CPU_PIA2_BASE = 16'he820;
    localparam logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] CPU_VIA_BASE  = 16'he840;
    localparam int CPU_CS_LSB = 4;          // Lowest chip select address bit
    localparam int CPU_CS_MSB = 6;          // Highest chip select address bit

endpackage

// File: rtl/pet_io_top.sv
/* PET I/O snooping top */

module pet_io_top (
    input  logic                               wb_clock_i,
    input  logic                               reset_i,

    // 6502 bus
    input  pet_bus_pkg::cpu_bus_t              cpu_bus_i,
    output logic                               cpu_be_o,       // CPU slot strobe
    output logic [pet_bus_pkg::DATA_WIDTH-1:0] cpu_data_o,
    output logic                               cpu_data_oe_o,  // Drive cpu_data_o onto the bus

    // Host Wishbone
    input  pet_bus_pkg::wb_req_t               wb_req_i,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0] wb_data_o,
    output logic                               wb_ack_o,
    output logic                               wb_stall_o
);
    import pet_io_pkg::*;

    logic                    pia1_cs;
    logic                    pia2_cs;
    logic                    via_cs;
    logic [VIA_RS_WIDTH-1:0] rs;
    logic                    wb_sel;

    bus_timing timing0 (
        .wb_clock_i (wb_clock_i),
        .reset_i    (reset_i),
        .cpu_be_o   (cpu_be_o)
    );

    address_decoding decode0 (
        .cpu_addr_i (cpu_bus_i.address),
        .wb_addr_i  (wb_req_i.address),
        .pia1_cs_o  (pia1_cs),
        .pia2_cs_o  (pia2_cs),
        .via_cs_o   (via_cs),
        .rs_o       (rs),
        .wb_sel_o   (wb_sel)
    );

    // Sees the same slot strobe as the CPU pins
    keyboard kbd0 (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .wb_req_i      (wb_req_i),
        .wb_sel_i      (wb_sel),
        .wb_data_o     (wb_data_o),
        .wb_ack_o      (wb_ack_o),
        .wb_stall_o    (wb_stall_o),
        .cpu_be_i      (cpu_be_o),
        .cpu_we_i      (cpu_bus_i.we),
        .cpu_data_i    (cpu_bus_i.data),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o),
        .pia1_cs_i     (pia1_cs),
        .pia2_cs_i     (pia2_cs),
        .via_cs_i      (via_cs),
        .rs_i          (rs)
    );

endmodule

// File: tb/pet_io_assert.sv
/* Keyboard protocol assertions */

module pet_io_assert (
    input logic                                wb_clock_i,
    input logic                                reset_i,
    input pet_bus_pkg::wb_req_t                wb_req_i,
    input logic                                wb_sel_i,
    input logic                                wb_stall_i,
    input logic                                wb_ack_i,
    input logic                                cpu_be_i,
    input logic                                cpu_we_i,
    input logic                                pia1_cs_i,
    input logic [pet_io_pkg::VIA_RS_WIDTH-1:0] rs_i,
    input logic                                cpu_data_oe_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import pet_io_pkg::*;

    logic accept;
    logic portb_read;

    assign accept     = wb_req_i.cycle && wb_req_i.strobe && wb_sel_i && !wb_stall_i;
    assign portb_read = cpu_be_i && !cpu_we_i && pia1_cs_i
                        && (rs_i[PIA_RS_WIDTH-1:0] == PIA_PORTB);   // Keyboard rows

    ack_after_accept: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        accept |=> wb_ack_i)
        else $error("Wishbone ack missing one cycle after acceptance");

    // CPU slot stalls the host, so nothing can complete right after it
    no_ack_after_cpu_slot: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        cpu_be_i |=> !wb_ack_i)
        else $error("Wishbone ack in the cycle after a CPU slot");

    oe_only_after_portb: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        cpu_data_oe_i |-> $past(portb_read))
        else $error("CPU data driven without a PIA1 port B read");

endmodule

bind keyboard pet_io_assert asrt0 (
    .wb_clock_i    (wb_clock_i),
    .reset_i       (reset_i),
    .wb_req_i      (wb_req_i),
    .wb_sel_i      (wb_sel_i),
    .wb_stall_i    (wb_stall_o),
    .wb_ack_i      (wb_ack_o),
    .cpu_be_i      (cpu_be_i),
    .cpu_we_i      (cpu_we_i),
    .pia1_cs_i     (pia1_cs_i),
    .rs_i          (rs_i),
    .cpu_data_oe_i (cpu_data_oe_o)
);

// File: tb/pet_io_tb.sv
/* PET I/O testbench */

module pet_io_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pet_bus_pkg::*;
    import pet_io_pkg::*;

    // Test length, one transaction costs at most two CPU slots plus a stall
    localparam int WB_RANDOM_OPS  = 200;
    localparam int CPU_RANDOM_OPS = 150;
    localparam int KEY_ROUNDS     = 40;
    localparam int TXN_COUNT      = 2 * IO_REG_COUNT + WB_RANDOM_OPS + CPU_RANDOM_OPS
                                    + 3 * KEY_ROUNDS;
    localparam int TIMEOUT_CYCLES = TXN_COUNT * 16 + 100;    // Margin covers reset

    localparam cpu_bus_t CPU_IDLE = '0;     // Zero page read, outside the I/O page
    localparam wb_req_t  WB_IDLE  = '0;

    logic                  wb_clock = 1'b0;
    logic                  reset;
    cpu_bus_t              cpu_bus;
    wb_req_t               wb_req;
    logic [DATA_WIDTH-1:0] wb_data;
    logic                  wb_ack;
    logic                  wb_stall;
    logic                  cpu_be;
    logic [DATA_WIDTH-1:0] cpu_data;
    logic                  cpu_data_oe;

    logic [DATA_WIDTH-1:0] model [IO_REG_COUNT];  // Expected register file
    logic [31:0]           seed = 32'hcd15;
    int                    slot_phase = 0;        // Expected position in the slot rotation

    pet_io_top dut0 (
        .wb_clock_i    (wb_clock),
        .reset_i       (reset),
        .cpu_bus_i     (cpu_bus),
        .cpu_be_o      (cpu_be),
        .cpu_data_o    (cpu_data),
        .cpu_data_oe_o (cpu_data_oe),
        .wb_req_i      (wb_req),
        .wb_data_o     (wb_data),
        .wb_ack_o      (wb_ack),
        .wb_stall_o    (wb_stall)
    );

    initial begin
        forever #2 wb_clock = ~wb_clock;    // 4 ns period
    end

    // LCG, halves swapped so the low bits are not short-period
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // Slot rotation, the CPU owns the last of every CPU_SLOT_CYCLES clocks
    always @(posedge wb_clock) begin
        if (reset) begin
            slot_phase <= 0;
        end else begin
            slot_phase <= (slot_phase + 1) % CPU_SLOT_CYCLES;
        end
    end

    // Strobe and back-pressure follow the rotation on every cycle
    always @(negedge wb_clock) begin
        check_value("cpu_be_o", slot_phase == CPU_SLOT_CYCLES - 1, cpu_be);
        check_value("wb_stall_o", slot_phase == CPU_SLOT_CYCLES - 1, wb_stall);
    end

    // Register file index a CPU address snoops into, -1 for none
    function automatic int snoop_index(input logic [CPU_ADDR_WIDTH-1:0] addr);
        if (addr[15:7] != CPU_PIA1_BASE[15:7]) begin
            return -1;                      // Outside E800..E87F
        end
        case (addr[6:4])                    // Only one chip select bit may be set
            3'b001:  return 16 + int'(addr[1:0]);   // PIA1 group
            3'b010:  return 32 + int'(addr[1:0]);   // PIA2 group
            3'b100:  return 48 + int'(addr[3:0]);   // VIA group, all four bits
            default: return -1;
        endcase
    endfunction

    // Mostly inside the I/O page so the chips get hit often
    function automatic logic [CPU_ADDR_WIDTH-1:0] random_cpu_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] != 2'b00) begin
            return {CPU_PIA1_BASE[15:7], r[6:0]};
        end
        return r[15:0];
    endfunction

    // One host request, held unchanged while stalled
    task automatic wb_access(input logic we, input logic [IO_REG_ADDR_WIDTH-1:0] reg_addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        wb_req.address = WB_IO_BASE | WB_ADDR_WIDTH'(reg_addr);
        wb_req.data    = wdata;
        wb_req.we      = we;
        wb_req.cycle   = 1'b1;
        wb_req.strobe  = 1'b1;
        while (cpu_be) begin                // Next edge is the CPU slot
            check_value("wb_stall_o", 1, wb_stall);
            @(negedge wb_clock);
            check_value("wb_ack_o", 0, wb_ack);
        end
        check_value("wb_stall_o", 0, wb_stall);
        @(negedge wb_clock);
        check_value("wb_ack_o", 1, wb_ack);
        check_value("wb_data_o", model[reg_addr], wb_data);  // Value before the write
        if (we) begin
            model[reg_addr] = wdata;
        end
        wb_req = WB_IDLE;
    endtask

    // Stops on a falling edge whose next rising edge is a CPU slot
    task automatic wait_cpu_slot();
        do begin
            @(negedge wb_clock);
            check_value("cpu_data_oe_o", 0, cpu_data_oe);    // Bus idle here
        end while (!cpu_be);
    endtask

    task automatic cpu_access(input logic [CPU_ADDR_WIDTH-1:0] addr, input logic we,
                              input logic [DATA_WIDTH-1:0] wdata);
        logic [DATA_WIDTH-1:0] column;
        logic                  expect_oe;
        int                    idx;
        // Skipping one slot leaves three idle cycles for the column pipeline
        wait_cpu_slot();
        wait_cpu_slot();
        column    = model[model[REG_IO_PIA1_PORTA][KEY_SEL_WIDTH-1:0]];
        idx       = snoop_index(addr);
        expect_oe = !we && (idx == 16 + int'(PIA_PORTB)) && (column != KEY_COL_IDLE);
        cpu_bus.address = addr;
        cpu_bus.data    = wdata;
        cpu_bus.we      = we;
        @(negedge wb_clock);
        cpu_bus = CPU_IDLE;
        check_value("cpu_data_oe_o", expect_oe, cpu_data_oe);
        if (expect_oe) begin
            check_value("cpu_data_o", column, cpu_data);      // Matrix rows
        end
        if (we && idx >= 0) begin
            model[idx] = wdata;
        end
    endtask

    initial begin
        logic [31:0]           r;
        logic [DATA_WIDTH-1:0] pattern;
        int                    col;
        reset   = 1'b1;
        cpu_bus = CPU_IDLE;
        wb_req  = WB_IDLE;
        for (int i = 0; i < IO_REG_COUNT; i++) begin
            model[i] = (i < KEY_COL_COUNT) ? KEY_COL_IDLE : '0;  // No keys pressed
        end
        repeat (5) begin
            @(negedge wb_clock);
            check_value("wb_ack_o", 0, wb_ack);
            check_value("cpu_data_oe_o", 0, cpu_data_oe);
            check_value("cpu_be_o", 0, cpu_be);
        end
        reset = 1'b0;
        for (int i = 1; i <= 3; i++) begin  // First CPU slot is the fourth cycle
            @(negedge wb_clock);
            check_value("cpu_be_o", i == 3, cpu_be);
        end

        // Reset contents through the host port
        for (int i = 0; i < IO_REG_COUNT; i++) begin
            wb_access(1'b0, IO_REG_ADDR_WIDTH'(i), '0);
        end

        // Random host traffic, gaps shift it against the slots
        for (int i = 0; i < WB_RANDOM_OPS; i++) begin
            r = next_rand();
            repeat (r[9:8]) @(negedge wb_clock);
            wb_access(r[31], r[5:0], r[23:16]);
        end

        // Snooped CPU writes and reads, then the whole file read back
        for (int i = 0; i < CPU_RANDOM_OPS; i++) begin
            r = next_rand();
            cpu_access(random_cpu_addr(), r[0], r[15:8]);
        end
        for (int i = 0; i < IO_REG_COUNT; i++) begin
            wb_access(1'b0, IO_REG_ADDR_WIDTH'(i), '0);
        end

        // Host presses keys, CPU scans the matrix
        for (int i = 0; i < KEY_ROUNDS; i++) begin
            r       = next_rand();
            col     = r[7:0] % KEY_COL_COUNT;
            pattern = (r[9:8] == 2'b00) ? KEY_COL_IDLE : r[23:16];  // Some released
            wb_access(1'b1, IO_REG_ADDR_WIDTH'(col), pattern);
            cpu_access(CPU_PIA1_BASE + 16'(PIA_PORTA), 1'b1, {r[31:28], 4'(col)});
            cpu_access(CPU_PIA1_BASE + 16'(PIA_PORTB), 1'b0, '0);
        end

        $display("TEST PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge wb_clock);
        report_error("watchdog expired before the test sequence finished");
    end

endmodule
